// ==== logic/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int DATA_WIDTH = 32;               // data word size
    localparam int PC_WIDTH   = 10;               // word-addressed pc, 1024 words
    localparam int ADDR_WIDTH = 10;               // data memory word address
    localparam int REG_WIDTH  = 5;                // register index
    localparam int MEM_DEPTH  = 1 << ADDR_WIDTH;  // data words
    localparam int REG_COUNT  = 1 << REG_WIDTH;   // architectural registers

    typedef enum logic [5:0] {
        OPC_ALU  = 6'd0,  // all-zero word is add r0 <- r0, r0, the nop
        OPC_ADDI = 6'd1,
        OPC_LW   = 6'd2,
        OPC_SW   = 6'd3,  // rd field names the store data register
        OPC_BEQ  = 6'd4,  // compares rd and rs1
        OPC_LUI  = 6'd5
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,  // signed
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } aluFunc_e;

    // register format view
    typedef struct packed {
        opcode_e              opcode;
        logic [REG_WIDTH-1:0] rd;
        logic [REG_WIDTH-1:0] rs1;
        logic [REG_WIDTH-1:0] rs2;
        logic [6:0]           unused;
        aluFunc_e             func;
    } rFmt_t;

    // immediate format view
    typedef struct packed {
        opcode_e              opcode;
        logic [REG_WIDTH-1:0] rd;
        logic [REG_WIDTH-1:0] rs1;
        logic [15:0]          imm;
    } iFmt_t;

    typedef union packed {
        rFmt_t rFmt;
        iFmt_t iFmt;
    } instWord_u;

    typedef struct packed {
        logic                 regWrite;  // result goes to rd
        logic                 memRead;   // result is load data
        logic                 memWrite;  // store
        logic                 isBranch;  // beq
        logic                 useImm;    // operand b from immediate
        aluFunc_e             aluFunc;
        logic [REG_WIDTH-1:0] rd;
    } ctrl_t;

    typedef struct packed {
        logic                  wrEn;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wrData;
    } memReq_t;

    typedef struct packed {
        logic                  en;
        logic [REG_WIDTH-1:0]  rd;
        logic [DATA_WIDTH-1:0] data;
    } wbReq_t;

endpackage

`default_nettype wire

// ==== logic/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                             i_Clock,
    input  logic                             i_rst,
    input  logic [cpuPkg::REG_WIDTH-1:0]     i_rdAddrA,
    input  logic [cpuPkg::REG_WIDTH-1:0]     i_rdAddrB,
    output logic [cpuPkg::DATA_WIDTH-1:0]    o_rdDataA,
    output logic [cpuPkg::DATA_WIDTH-1:0]    o_rdDataB,
    input  cpuPkg::wbReq_t                   i_wb
);
    import cpuPkg::*;

    logic [DATA_WIDTH-1:0] regs [0:REG_COUNT-1];  // no reset, contents survive
    logic                  wbHit;                 // a real write this cycle

    assign wbHit = i_wb.en && (i_wb.rd != '0);  // r0 is never written

    always_ff @(posedge i_Clock) begin
        if (wbHit && !i_rst) begin  // state frozen while in reset
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // r0 reads zero, a read of the reg being written sees the new value
    always_comb begin
        if (i_rdAddrA == '0) o_rdDataA = '0;
        else if (wbHit && (i_wb.rd == i_rdAddrA)) o_rdDataA = i_wb.data;
        else o_rdDataA = regs[i_rdAddrA];
        if (i_rdAddrB == '0) o_rdDataB = '0;
        else if (wbHit && (i_wb.rd == i_rdAddrB)) o_rdDataB = i_wb.data;
        else o_rdDataB = regs[i_rdAddrB];
    end

endmodule

`default_nettype wire

// ==== logic/arithUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module arithUnit (
    input  cpuPkg::aluFunc_e                 i_func,
    input  logic [cpuPkg::DATA_WIDTH-1:0]    i_opA,
    input  logic [cpuPkg::DATA_WIDTH-1:0]    i_opB,
    output logic [cpuPkg::DATA_WIDTH-1:0]    o_result,
    output logic                             o_equal
);
    import cpuPkg::*;

    logic [4:0] shAmt;  // shifts take low five bits of b
    logic       less;   // signed a < b

    assign shAmt   = i_opB[4:0];
    assign less    = $signed(i_opA) < $signed(i_opB);
    assign o_equal = (i_opA == i_opB);  // branch compare

    always_comb begin
        case (i_func)
            ALU_ADD: o_result = i_opA + i_opB;
            ALU_SUB: o_result = i_opA - i_opB;
            ALU_AND: o_result = i_opA & i_opB;
            ALU_OR:  o_result = i_opA | i_opB;
            ALU_XOR: o_result = i_opA ^ i_opB;
            ALU_SLT: o_result = {{(DATA_WIDTH-1){1'b0}}, less};  // 0 or 1
            ALU_SLL: o_result = i_opA << shAmt;
            ALU_SRL: o_result = i_opA >> shAmt;                  // logical
            default: o_result = '0;                              // unused codes
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/instDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
    input  cpuPkg::instWord_u                i_inst,
    output cpuPkg::ctrl_t                    o_ctrl,
    output logic [cpuPkg::DATA_WIDTH-1:0]    o_imm
);
    import cpuPkg::*;

    logic [DATA_WIDTH-1:0] immSext;  // sign-extended 16-bit field
    logic [DATA_WIDTH-1:0] immUpper; // lui placement

    assign immSext  = {{(DATA_WIDTH-16){i_inst.iFmt.imm[15]}}, i_inst.iFmt.imm};
    assign immUpper = {i_inst.iFmt.imm, 16'h0000};

    always_comb begin
        o_ctrl    = '0;               // nop defaults
        o_ctrl.rd = i_inst.rFmt.rd;   // same bits in both views
        o_imm     = immSext;
        case (i_inst.rFmt.opcode)
            OPC_ALU: begin
                o_ctrl.regWrite = 1'b1;
                o_ctrl.aluFunc  = i_inst.rFmt.func;  // register view
            end
            OPC_ADDI: begin
                o_ctrl.regWrite = 1'b1;
                o_ctrl.useImm   = 1'b1;
                o_ctrl.aluFunc  = ALU_ADD;
            end
            OPC_LW: begin
                o_ctrl.regWrite = 1'b1;
                o_ctrl.memRead  = 1'b1;
                o_ctrl.useImm   = 1'b1;              // base + offset
                o_ctrl.aluFunc  = ALU_ADD;
            end
            OPC_SW: begin
                o_ctrl.memWrite = 1'b1;              // rd is the data source
                o_ctrl.useImm   = 1'b1;
                o_ctrl.aluFunc  = ALU_ADD;
            end
            OPC_BEQ: begin
                o_ctrl.isBranch = 1'b1;              // imm is the pc offset
                o_ctrl.aluFunc  = ALU_SUB;
            end
            OPC_LUI: begin
                o_ctrl.regWrite = 1'b1;
                o_ctrl.useImm   = 1'b1;              // 0 + imm << 16
                o_ctrl.aluFunc  = ALU_ADD;
                o_imm           = immUpper;
            end
            default: begin
                o_ctrl.rd = '0;                      // unknown opcode, no-op
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/dataMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataMemory (
    input  logic                             i_Clock,
    input  cpuPkg::memReq_t                  i_req,
    output logic [cpuPkg::DATA_WIDTH-1:0]    o_rdData
);
    import cpuPkg::*;

    logic [DATA_WIDTH-1:0] mem [0:MEM_DEPTH-1];  // word array, not cleared

    always_ff @(posedge i_Clock) begin
        if (i_req.wrEn) begin
            mem[i_req.addr] <= i_req.wrData;  // store lands at end of execute
        end
    end

    assign o_rdData = mem[i_req.addr];  // async read, load data same cycle

endmodule

`default_nettype wire

// ==== logic/processorPipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module processorPipe (
    input  logic                             i_Clock,
    input  logic                             i_rst,
    output logic [cpuPkg::PC_WIDTH-1:0]      o_pgmAddr,
    input  cpuPkg::instWord_u                i_pgmInst,
    output cpuPkg::memReq_t                  o_memReq,
    input  logic [cpuPkg::DATA_WIDTH-1:0]    i_memRdData
);
    import cpuPkg::*;

    // fetch stage state
    logic [PC_WIDTH-1:0]   pcReg;         // drives the program rom
    instWord_u             instReg;       // instruction in execute
    logic [PC_WIDTH-1:0]   instPc;        // its own address, for branch target
    wbReq_t                wbReg;         // writeback stage

    // execute stage
    ctrl_t                 ctrl;
    logic [DATA_WIDTH-1:0] imm;
    logic [REG_WIDTH-1:0]  rdAddrA;
    logic [REG_WIDTH-1:0]  rdAddrB;
    logic [DATA_WIDTH-1:0] rdDataA;
    logic [DATA_WIDTH-1:0] rdDataB;
    logic [DATA_WIDTH-1:0] opA;           // rs1 value with writeback bypass
    logic [DATA_WIDTH-1:0] opB;           // rs2 or rd value with writeback bypass
    logic [DATA_WIDTH-1:0] aluB;          // after immediate mux
    logic [DATA_WIDTH-1:0] aluResult;
    logic                  aluEqual;
    logic                  branchTaken;
    logic [PC_WIDTH-1:0]   branchTarget;
    wbReq_t                wbNext;

    assign o_pgmAddr = pcReg;

    // lui reads r0 as operand a, alu ops read rs2 on port b, sw and beq read rd
    assign rdAddrA = (instReg.iFmt.opcode == OPC_LUI) ? '0 : instReg.iFmt.rs1;
    assign rdAddrB = (instReg.rFmt.opcode == OPC_ALU) ? instReg.rFmt.rs2
                                                      : instReg.rFmt.rd;

    instDecoder decoder_inst (
        .i_inst (instReg),
        .o_ctrl (ctrl),
        .o_imm  (imm)
    );

    registerFile regFile_inst (
        .i_Clock   (i_Clock),
        .i_rst     (i_rst),
        .i_rdAddrA (rdAddrA),
        .i_rdAddrB (rdAddrB),
        .o_rdDataA (rdDataA),
        .o_rdDataB (rdDataB),
        .i_wb      (wbReg)
    );

    // the register file returns the wb data on an rd match, previous result included
    assign opA = rdDataA;
    assign opB = rdDataB;
    assign aluB = ctrl.useImm ? imm : opB;

    arithUnit alu_inst (
        .i_func   (ctrl.aluFunc),
        .i_opA    (opA),
        .i_opB    (aluB),
        .o_result (aluResult),
        .o_equal  (aluEqual)
    );

    // branch resolves in execute, target wraps at pc width
    assign branchTaken  = ctrl.isBranch && aluEqual;
    assign branchTarget = instPc + PC_WIDTH'(1) + imm[PC_WIDTH-1:0];

    // data memory access, address from alu, store data is forwarded rd
    assign o_memReq.wrEn   = ctrl.memWrite;
    assign o_memReq.addr   = aluResult[ADDR_WIDTH-1:0];
    assign o_memReq.wrData = opB;

    always_comb begin
        wbNext.en   = ctrl.regWrite;
        wbNext.rd   = ctrl.rd;
        wbNext.data = ctrl.memRead ? i_memRdData : aluResult;  // load or alu
    end

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            pcReg   <= '0;
            instReg <= '0;   // zero word is the nop
            instPc  <= '0;
            wbReg   <= '0;   // no write pending
        end else begin
            wbReg  <= wbNext;
            instPc <= pcReg;
            if (branchTaken) begin
                pcReg   <= branchTarget;
                instReg <= '0;  // squash the wrong-path fetch, one bubble
            end else begin
                pcReg   <= pcReg + PC_WIDTH'(1);
                instReg <= i_pgmInst;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
    input  logic                             i_Clock,
    input  logic                             i_rst,
    output logic [cpuPkg::PC_WIDTH-1:0]      o_pgmAddr,  // to external program rom
    input  cpuPkg::instWord_u                i_pgmInst,  // comb return from rom
    output cpuPkg::memReq_t                  o_memWr     // mirror for leds / gpio
);
    import cpuPkg::*;

    memReq_t               memReq;     // core to ram
    logic [DATA_WIDTH-1:0] memRdData;  // ram to core

    processorPipe cpu_inst (
        .i_Clock     (i_Clock),
        .i_rst       (i_rst),
        .o_pgmAddr   (o_pgmAddr),
        .i_pgmInst   (i_pgmInst),
        .o_memReq    (memReq),
        .i_memRdData (memRdData)
    );

    dataMemory mem_inst (
        .i_Clock  (i_Clock),
        .i_req    (memReq),
        .o_rdData (memRdData)
    );

    assign o_memWr = memReq;  // observation copy of the write port

endmodule

`default_nettype wire

// ==== verif/tbAsm.svh ====
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// opcode 31:26, rd 25:21, rs1 20:16, then rs2 15:11 and func 3:0
function automatic logic [31:0] packR(input opcode_e opc, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [4:0] rs2,
                                      input aluFunc_e fn);
    return {opc, rd, rs1, rs2, 7'b0000000, fn};
endfunction

// immediate form, imm in 15:0
function automatic logic [31:0] packI(input opcode_e opc, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [15:0] imm);
    return {opc, rd, rs1, imm};
endfunction

function automatic logic [31:0] aluInst(input aluFunc_e fn, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
    return packR(OPC_ALU, rd, rs1, rs2, fn);
endfunction

function automatic logic [31:0] addiInst(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [15:0] imm);
    return packI(OPC_ADDI, rd, rs1, imm);
endfunction

function automatic logic [31:0] loadInst(input logic [4:0] rd, input logic [4:0] base,
                                         input logic [15:0] off);
    return packI(OPC_LW, rd, base, off);
endfunction

// data register sits in the rd field
function automatic logic [31:0] storeInst(input logic [4:0] src, input logic [4:0] base,
                                          input logic [15:0] off);
    return packI(OPC_SW, src, base, off);
endfunction

function automatic logic [31:0] branchInst(input logic [4:0] ra, input logic [4:0] rb,
                                           input logic [15:0] off);
    return packI(OPC_BEQ, ra, rb, off);  // target is pc + 1 + off
endfunction

function automatic logic [31:0] luiInst(input logic [4:0] rd, input logic [15:0] imm);
    return packI(OPC_LUI, rd, 5'd0, imm);
endfunction

function automatic logic [31:0] haltInst();
    return branchInst(5'd0, 5'd0, 16'hFFFF);  // beq r0, r0, -1 spins in place
endfunction

`endif

// ==== verif/cpuTopTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTopTb;
    import cpuPkg::*;

    localparam int RESET_CYCLES  = 16;
    localparam int STORE_TIMEOUT = 2000;  // cycles per wait
    localparam int QUIET_CYCLES  = 20;    // watch window for extra stores
    localparam int MODEL_STEPS   = 5000;
    localparam int SEED          = 80;
    localparam int PGM_WORDS     = 1 << PC_WIDTH;

    logic                  clock;
    logic                  rst;
    logic [PC_WIDTH-1:0]   pgmAddr;
    instWord_u             pgmInst;
    memReq_t               memWr;

    logic [31:0]           pgmMem    [0:PGM_WORDS-1];  // rom the dut fetches from
    logic [31:0]           nextPgm   [0:PGM_WORDS-1];  // program under construction
    int                    pgmLen;
    logic [31:0]           dataModel [0:MEM_DEPTH-1];
    logic [ADDR_WIDTH-1:0] expAddr   [$];
    logic [31:0]           expData   [$];
    memReq_t               storeQ    [$];              // stores seen out of reset
    int                    resetStores;                // stores seen with reset high
    int                    errorCount;
    int                    checkCount;

    `include "tbAsm.svh"

    cpuTop cpuTop_inst (
        .i_Clock   (clock),
        .i_rst     (rst),
        .o_pgmAddr (pgmAddr),
        .i_pgmInst (pgmInst),
        .o_memWr   (memWr)
    );

    assign pgmInst = pgmMem[pgmAddr];  // combinational rom

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;  // 8 ns period
    end

    // sampled mid-cycle, away from the rising-edge drives
    always @(negedge clock) begin
        if (memWr.wrEn === 1'b1) begin
            if (rst) resetStores++;
            else storeQ.push_back(memWr);
        end
    end

    function automatic logic [31:0] aluRef(input logic [3:0] fn, input logic [31:0] a,
                                           input logic [31:0] b);
        case (fn)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return '0;
        endcase
    endfunction

    // instruction-level model of the loaded program, fills the expected store list
    task automatic runModel();
        logic [31:0]         regs [0:31];
        logic [31:0]         word;
        logic [31:0]         immS;
        logic [31:0]         valA;
        logic [31:0]         valB;
        logic [31:0]         valD;
        logic [31:0]         addr;
        logic [PC_WIDTH-1:0] pc;
        logic [PC_WIDTH-1:0] nextPc;
        int                  steps;
        bit                  halted;
        expAddr.delete();
        expData.delete();
        for (int i = 0; i < 32; i++) regs[i] = '0;
        pc = '0;
        steps = 0;
        halted = 1'b0;
        while (!halted && steps < MODEL_STEPS) begin
            word   = pgmMem[pc];
            immS   = {{16{word[15]}}, word[15:0]};
            valA   = regs[word[20:16]];  // rs1
            valB   = regs[word[15:11]];  // rs2
            valD   = regs[word[25:21]];  // rd field, store data and beq operand
            addr   = valA + immS;
            nextPc = pc + PC_WIDTH'(1);
            case (word[31:26])
                OPC_ALU:  regs[word[25:21]] = aluRef(word[3:0], valA, valB);
                OPC_ADDI: regs[word[25:21]] = addr;
                OPC_LW:   regs[word[25:21]] = dataModel[addr[ADDR_WIDTH-1:0]];
                OPC_SW: begin
                    dataModel[addr[ADDR_WIDTH-1:0]] = valD;
                    expAddr.push_back(addr[ADDR_WIDTH-1:0]);
                    expData.push_back(valD);
                end
                OPC_BEQ: begin
                    if (valD == valA) begin
                        nextPc = pc + PC_WIDTH'(1) + immS[PC_WIDTH-1:0];  // wraps
                        halted = (nextPc == pc);
                    end
                end
                OPC_LUI:  regs[word[25:21]] = {word[15:0], 16'h0000};
                default:  ;  // unknown opcode does nothing
            endcase
            regs[0] = '0;
            pc = nextPc;
            steps++;
        end
        if (!halted) begin
            errorCount++;
            $display("reference model never reached the halt loop");
        end
    endtask

    task automatic newProgram();
        for (int i = 0; i < PGM_WORDS; i++) nextPgm[i] = '0;  // nop everywhere
        pgmLen = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        nextPgm[pgmLen] = word;
        pgmLen++;
    endtask

    // called on a rising edge; the new program goes in once the core is held idle
    task automatic applyReset(input string name, input bit loadPgm);
        rst <= 1'b1;
        @(posedge clock);
        if (loadPgm) begin
            for (int i = 0; i < PGM_WORDS; i++) pgmMem[i] = nextPgm[i];
        end
        repeat (RESET_CYCLES - 1) @(posedge clock);
        rst <= 1'b0;
        checkCount++;
        assert (resetStores == 0) else begin
            errorCount++;
            $display("error %s: stores in reset expected %0d actual %0d", name, 0, resetStores);
        end
        checkCount++;
        assert (pgmAddr == '0) else begin  // pc held at the first word
            errorCount++;
            $display("error %s: pc in reset expected %h actual %h",
                     name, PC_WIDTH'(0), pgmAddr);
        end
        resetStores = 0;
        storeQ.delete();
    endtask

    task automatic checkStores(input string name);
        int waited;
        waited = 0;
        while (storeQ.size() < expAddr.size() && waited < STORE_TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (storeQ.size() < expAddr.size()) begin
            errorCount++;
            $display("%s timed out with %0d of %0d stores", name, storeQ.size(), expAddr.size());
        end
        repeat (QUIET_CYCLES) @(posedge clock);  // halt loop must stay silent
        checkCount++;
        assert (storeQ.size() == expAddr.size()) else begin
            errorCount++;
            $display("error %s: store count expected %0d actual %0d",
                     name, expAddr.size(), storeQ.size());
        end
        for (int i = 0; i < expAddr.size() && i < storeQ.size(); i++) begin
            checkCount++;
            assert (storeQ[i].addr == expAddr[i]) else begin
                errorCount++;
                $display("error %s: store %0d addr expected %h actual %h",
                         name, i, expAddr[i], storeQ[i].addr);
            end
            assert (storeQ[i].wrData == expData[i]) else begin
                errorCount++;
                $display("error %s: store %0d data expected %h actual %h",
                         name, i, expData[i], storeQ[i].wrData);
            end
        end
    endtask

    // lui + addi pair that rebuilds a full word despite the sign-extended low half
    task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
        emit(luiInst(rd, value[31:16] + 16'(value[15])));
        emit(addiInst(rd, rd, value[15:0]));
    endtask

    task automatic testAluOps();
        int prev;
        newProgram();
        loadConst(5'd1, $urandom());
        loadConst(5'd2, $urandom());
        prev = 1;
        for (int k = 0; k < 8; k++) begin  // each op consumes the one before it
            if (k % 2 == 0) emit(aluInst(aluFunc_e'(k), 5'(k + 3), 5'(prev), 5'd2));
            else emit(aluInst(aluFunc_e'(k), 5'(k + 3), 5'd1, 5'(prev)));
            prev = k + 3;
        end
        for (int k = 0; k < 8; k++) emit(storeInst(5'(k + 3), 5'd0, 16'(16'h100 + k)));
        emit(haltInst());
        applyReset("aluOps", 1'b1);
        runModel();
        checkStores("aluOps");
    endtask

    task automatic testLoads();
        newProgram();
        emit(addiInst(5'd6, 5'd0, 16'h0200));  // base pointer
        for (int i = 0; i < 4; i++) begin
            loadConst(5'd5, $urandom());
            emit(storeInst(5'd5, 5'd6, 16'(i)));  // data forwarded from the addi
        end
        for (int i = 0; i < 4; i++) begin
            emit(loadInst(5'd7, 5'd6, 16'(i)));
            emit(addiInst(5'd8, 5'd7, 16'($urandom())));  // uses the load at once
            emit(storeInst(5'd8, 5'd0, 16'(16'h210 + i)));
        end
        emit(haltInst());
        applyReset("loads", 1'b1);
        runModel();
        checkStores("loads");
    endtask

    task automatic testBranches();
        newProgram();
        emit(addiInst(5'd1, 5'd0, 16'd5));
        emit(addiInst(5'd2, 5'd0, 16'd5));
        emit(branchInst(5'd1, 5'd2, 16'd2));        // taken, skips the next two
        emit(storeInst(5'd1, 5'd0, 16'h0300));
        emit(storeInst(5'd2, 5'd0, 16'h0301));
        emit(addiInst(5'd3, 5'd0, 16'd7));
        emit(branchInst(5'd1, 5'd3, 16'd1));        // not taken
        emit(storeInst(5'd3, 5'd0, 16'h0302));
        emit(addiInst(5'd4, 5'd0, 16'd0));          // loop counter
        emit(addiInst(5'd5, 5'd0, 16'd3));
        emit(addiInst(5'd4, 5'd4, 16'd1));
        emit(storeInst(5'd4, 5'd0, 16'h0303));
        emit(branchInst(5'd4, 5'd5, 16'd1));        // exit after third pass
        emit(branchInst(5'd0, 5'd0, -16'sd4));      // back to the increment
        emit(haltInst());
        applyReset("branches", 1'b1);
        runModel();
        checkStores("branches");
    endtask

    task automatic testRegZero();
        newProgram();
        emit(addiInst(5'd0, 5'd0, 16'h1234));
        emit(storeInst(5'd0, 5'd0, 16'h03F0));      // no forward for r0
        emit(addiInst(5'd1, 5'd0, 16'h0077));
        emit(addiInst(5'd0, 5'd1, 16'h0005));
        emit(storeInst(5'd0, 5'd0, 16'h03F1));
        emit(storeInst(5'd1, 5'd0, 16'h03F2));
        emit(haltInst());
        applyReset("regZero", 1'b1);
        runModel();
        checkStores("regZero");
    endtask

    task automatic testMidReset();
        int waited;
        newProgram();
        for (int i = 0; i < 4; i++) begin           // stores alternate with addi
            emit(addiInst(5'(i + 1), 5'd0, 16'($urandom())));
            emit(storeInst(5'(i + 1), 5'd0, 16'(16'h380 + i)));
        end
        emit(haltInst());
        applyReset("midReset", 1'b1);
        runModel();
        waited = 0;
        while (storeQ.size() < 2 && waited < STORE_TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (storeQ.size() < 2) begin
            errorCount++;
            $display("midReset timed out before the second store");
        end
        for (int i = 0; i < 2 && i < storeQ.size(); i++) begin
            checkCount++;
            assert (storeQ[i].wrData == expData[i]) else begin
                errorCount++;
                $display("error midReset: early store %0d expected %h actual %h",
                         i, expData[i], storeQ[i].wrData);
            end
        end
        applyReset("midReset", 1'b0);  // an addi is in execute here, the next store is not
        checkStores("midReset");        // whole sequence again from the first store
    endtask

    initial begin
        rst <= 1'b1;
        errorCount  = 0;
        checkCount  = 0;
        resetStores = 0;
        pgmLen      = 0;
        for (int i = 0; i < PGM_WORDS; i++) pgmMem[i] = '0;
        void'($urandom(SEED));
        testAluOps();
        testLoads();
        testBranches();
        testRegZero();
        testMidReset();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpuTop.f ====
+incdir+verif
logic/cpuPkg.sv
logic/registerFile.sv
logic/arithUnit.sv
logic/instDecoder.sv
logic/dataMemory.sv
logic/processorPipe.sv
logic/cpuTop.sv
verif/cpuTopTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpuTopTb
FILELIST  ?= cpuTop.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard verif/*.svh)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)
